// File: list.f
+incdir+rtl
+incdir+bench
rtl/io_pkg.sv
rtl/io_bram.sv
rtl/io_req_queue.sv
rtl/io_addr_decode.sv
rtl/io_top.sv
bench/io_tb.sv

// File: Bender.yml
package:
  name: io_bram_path

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/io_pkg.sv
      - rtl/io_bram.sv
      - rtl/io_req_queue.sv
      - rtl/io_addr_decode.sv
      - rtl/io_top.sv
  - target: test
    include_dirs:
      - rtl
      - bench
    files:
      - bench/io_tb.sv

// File: bench/io_tb_model.svh
// io testbench model, byte image of the RAM window, expected responses and host credits

`ifndef IO_TB_MODEL_SVH
`define IO_TB_MODEL_SVH

logic [7:0]       model_mem [2**`BRAM_SIZE_LOG2];
bit               model_vld [2**`BRAM_SIZE_LOG2];   // byte written at least once
io_pkg::io_resp_t exp_q [$];                        // in request order
io_pkg::io_data_t mask_q [$];                       // rdata bits worth checking
int               req_credits = `REQ_DEPTH;
int               req_sent, credit_pulses, resp_granted, resp_received;

// word address in the first 16 rows, so lanes share rows
function automatic io_pkg::io_addr_t window_word(input int r);
   return `BRAM_BASE | io_pkg::io_addr_t'({r[5:0], 2'b00});
endfunction

// update the model, queue the expected response, then put one request on the bus
task automatic send_req(input logic wr, input io_pkg::io_addr_t a,
                        input io_pkg::io_data_t d, input io_pkg::io_strb_t s);
   io_pkg::io_resp_t exp_r;
   io_pkg::io_data_t mask;
   int               off;
   exp_r = '0;
   mask  = '0;
   off   = int'(a[`BRAM_SIZE_LOG2-1:2]) * 4;
   if ((a & `BRAM_MASK) != `BRAM_BASE) begin
      exp_r.err = 1'b1;   // zero data, all of it checked
      mask      = '1;
   end else begin
      for (int b = 0; b < 4; b++) begin
         if (wr && s[b]) begin
            model_mem[off+b] = d[b*8 +: 8];
            model_vld[off+b] = 1'b1;
         end else if (!wr && model_vld[off+b]) begin
            exp_r.rdata[b*8 +: 8] = model_mem[off+b];
            mask[b*8 +: 8]        = 8'hff;
         end
      end
   end
   @(posedge ram_clk);
   while (req_credits == 0) begin
      req_valid_i <= 1'b0;
      @(posedge ram_clk);
   end
   req_valid_i <= 1'b1;
   req_i       <= io_pkg::io_req_t'{write: wr, addr: a, wdata: d, strb: s};
   req_credits = req_credits - 1;
   req_sent    = req_sent + 1;
   exp_q.push_back(exp_r);
   mask_q.push_back(mask);
endtask

task automatic idle(input int n);
   repeat (n) begin
      @(posedge ram_clk);
      req_valid_i <= 1'b0;
   end
endtask

// every outstanding response received
task automatic drain();
   idle(1);
   while (exp_q.size() != 0) @(negedge ram_clk);
endtask

`endif

// File: bench/io_tb.sv
// io testbench, random host traffic through the block RAM path against a byte model

`timescale 1ns/100ps
`default_nettype none

`include "io_macros.svh"

module io_tb;

   localparam int N_RW       = 64;
   localparam int N_UNMAP    = 16;
   localparam int N_LONG     = 200;
   localparam int TOTAL_REQ  = 1 + 2 * N_RW + 2 * N_UNMAP + 2 * `REQ_DEPTH + N_LONG;
   localparam int WDOG_CYC   = TOTAL_REQ * 20 + 200;
   localparam int GRANT_NONE = 0;
   localparam int GRANT_ALL  = 1;
   localparam int GRANT_RAND = 2;

   logic             ram_clk;
   logic             rst_n_i;
   logic             req_valid_i;
   io_pkg::io_req_t  req_i;
   logic             req_credit_o;
   logic             resp_credit_i;
   logic             resp_valid_o;
   io_pkg::io_resp_t resp_o;

   integer seed       = 32'h0c11_2533;
   integer grant_seed = ~32'h0c11_2533;   // separate stream for credit grants
   int     grant_mode = GRANT_NONE;
   bit     grant_one;
   string  test_name  = "reset";
   int     test_errors, tests_passed, tests_failed;

   `include "io_tb_model.svh"

   io_top io_top_i (.*);

   initial begin
      ram_clk = 1'b0;
      forever #50 ram_clk = ~ram_clk;
   end

   task automatic report_value(input string what, input logic [31:0] exp_v,
                               input logic [31:0] act_v);
      $display("ERROR %s %s: expected %h actual %h", test_name, what, exp_v, act_v);
      test_errors++;
   endtask

   task automatic report_fail(input string msg);
      $display("test %s: %s", test_name, msg);
      test_errors++;
   endtask

   task automatic finish_test(input string next);
      if (test_errors == 0) begin
         $display("test %s: ok", test_name);
         tests_passed++;
      end else begin
         $display("test %s: %0d errors", test_name, test_errors);
         tests_failed++;
      end
      test_errors = 0;
      test_name   = next;
   endtask

   task automatic set_grant(input int mode);
      @(negedge ram_clk);
      grant_mode = mode;
   endtask

   ////////////////////////////////////////////////////////////
   // host side, response credits and response checks

   always @(posedge ram_clk) begin : grant
      int   rnd;
      logic g;
      rnd = $random(grant_seed);
      g   = (grant_mode == GRANT_ALL) || (grant_mode == GRANT_RAND && rnd[0]);
      if (resp_granted - resp_received >= exp_q.size()) g = 1'b0;   // only what is owed
      if (grant_one) begin
         g         = 1'b1;
         grant_one = 1'b0;
      end
      resp_credit_i <= g;
   end

   always @(negedge ram_clk) begin : monitor
      io_pkg::io_resp_t exp_r;
      io_pkg::io_data_t mask;
      if (rst_n_i) begin
         if (req_credit_o) begin
            req_credits++;
            credit_pulses++;
            if (req_credits > `REQ_DEPTH) report_fail("more request credits back than sent");
         end
         if (resp_credit_i) resp_granted++;
         if (resp_valid_o) begin
            resp_received++;
            if (resp_received > resp_granted) report_fail("more responses than credits granted");
            if (exp_q.size() == 0) begin
               report_fail("response with no request outstanding");
            end else begin
               exp_r = exp_q.pop_front();
               mask  = mask_q.pop_front();
               if (resp_o.err !== exp_r.err) report_value("err", exp_r.err, resp_o.err);
               if ((resp_o.rdata & mask) !== (exp_r.rdata & mask))
                  report_value("rdata", exp_r.rdata & mask, resp_o.rdata & mask);
            end
         end
      end
   end

   initial begin : watchdog
      repeat (WDOG_CYC) @(posedge ram_clk);
      $display("timeout: no progress after %0d cycles", WDOG_CYC);
      $display("tests failed");
      $finish;
   end

   ////////////////////////////////////////////////////////////
   // stimulus

   initial begin : stimulus
      io_pkg::io_addr_t a;
      int               rnd;
      int               base_rx;
      int               base_sent;
      int               base_pulses;
      rst_n_i       = 1'b0;
      req_valid_i   = 1'b0;
      req_i         = '0;
      resp_credit_i = 1'b0;

      @(posedge ram_clk);   // registers clear on the first edge
      for (int i = 0; i < 13; i++) begin
         @(negedge ram_clk);
         if (resp_valid_o !== 1'b0 || req_credit_o !== 1'b0) begin
            report_fail("outputs not low around reset");
         end
         if (i == 8) begin
            @(posedge ram_clk);
            rst_n_i <= 1'b1;
         end
      end
      send_req(1'b0, `BRAM_BASE, '0, '0);
      idle(10);
      if (resp_received != 0) report_fail("response sent without a response credit");
      set_grant(GRANT_ALL);
      drain();
      finish_test("ram write read");

      for (int i = 0; i < 2 * N_RW; i++) begin
         rnd = $random(seed);
         send_req(i < N_RW, window_word(rnd), $random(seed), rnd[11:8]);
      end
      drain();
      finish_test("unmapped");

      // miss, then the window word with the same offset
      for (int i = 0; i < N_UNMAP; i++) begin
         rnd = $random(seed);
         a   = {rnd[31:28], 4'h0, rnd[7:2], 2'b00};
         if ((a & `BRAM_MASK) == `BRAM_BASE) a = a ^ 16'h1000;
         send_req(rnd[8], a, $random(seed), 4'hf);
         send_req(1'b0, `BRAM_BASE | (a & ~`BRAM_MASK), '0, '0);
      end
      drain();
      finish_test("response back-pressure");

      for (int i = 0; i < `REQ_DEPTH; i++) send_req(1'b1, window_word(i), $random(seed), 4'hf);
      drain();
      set_grant(GRANT_NONE);
      base_rx = resp_received;
      for (int i = 0; i < `REQ_DEPTH; i++) send_req(1'b0, window_word(i), '0, '0);
      idle(20);
      if (req_credits != 0) report_fail("request credit came back while responses were held");
      if (resp_received != base_rx) report_fail("response sent without a response credit");
      for (int i = 1; i <= `REQ_DEPTH; i++) begin
         @(negedge ram_clk);
         grant_one = 1'b1;
         while (resp_received < base_rx + i) @(negedge ram_clk);
         repeat (4) @(negedge ram_clk);
         if (resp_received != base_rx + i) report_value("responses", base_rx + i, resp_received);
      end
      drain();
      finish_test("request credit return");

      set_grant(GRANT_RAND);
      base_sent   = req_sent;
      base_pulses = credit_pulses;
      for (int i = 0; i < N_LONG; i++) begin
         rnd = $random(seed);
         a   = window_word(rnd);
         if (rnd[9:8] == 2'b00) a = a ^ 16'h4000;   // about a quarter miss
         send_req(rnd[10], a, $random(seed), rnd[14:11]);
      end
      set_grant(GRANT_ALL);
      drain();
      if (credit_pulses - base_pulses != req_sent - base_sent)
         report_value("credit pulses", req_sent - base_sent, credit_pulses - base_pulses);
      finish_test("");

      $display("summary: %0d passed, %0d failed", tests_passed, tests_failed);
      if (tests_failed == 0) begin
         $display("all tests passed");
      end else begin
         $display("tests failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

// File: rtl/io_top.sv
// io top, request queue feeding the address decoder and the block RAM

`timescale 1ns/100ps
`default_nettype none

module io_top (
   input  wire              ram_clk,
   input  wire              rst_n_i,
   input  wire              req_valid_i,
   input  io_pkg::io_req_t  req_i,
   output logic             req_credit_o,
   input  wire              resp_credit_i,
   output logic             resp_valid_o,
   output io_pkg::io_resp_t resp_o
);

   // queue head
   logic            deq_valid;
   logic            deq_pop;
   io_pkg::io_req_t deq_req;

   // RAM port
   logic             ram_en;
   io_pkg::io_strb_t ram_we;
   io_pkg::io_addr_t ram_addr;
   io_pkg::io_data_t ram_wdata;
   io_pkg::io_data_t ram_rdata;

   io_req_queue io_req_queue_i (
      .ram_clk      ( ram_clk      ),
      .rst_n_i      ( rst_n_i      ),
      .req_valid_i  ( req_valid_i  ),
      .req_i        ( req_i        ),
      .deq_pop_i    ( deq_pop      ),
      .deq_valid_o  ( deq_valid    ),
      .deq_req_o    ( deq_req      ),
      .req_credit_o ( req_credit_o )
   );

   io_addr_decode io_addr_decode_i (
      .ram_clk       ( ram_clk       ),
      .rst_n_i       ( rst_n_i       ),
      .deq_valid_i   ( deq_valid     ),
      .deq_req_i     ( deq_req       ),
      .deq_pop_o     ( deq_pop       ),
      .resp_credit_i ( resp_credit_i ),
      .ram_en_o      ( ram_en        ),
      .ram_we_o      ( ram_we        ),
      .ram_addr_o    ( ram_addr      ),
      .ram_wdata_o   ( ram_wdata     ),
      .ram_rdata_i   ( ram_rdata     ),
      .resp_valid_o  ( resp_valid_o  ),
      .resp_o        ( resp_o        )
   );

   io_bram io_bram_i (
      .ram_clk     ( ram_clk   ),
      .ram_en_i    ( ram_en    ),
      .ram_we_i    ( ram_we    ),
      .ram_addr_i  ( ram_addr  ),
      .ram_wdata_i ( ram_wdata ),
      .ram_rdata_o ( ram_rdata )
   );

endmodule

`default_nettype wire

// File: rtl/io_addr_decode.sv
// io address decoder, routes the queue head to the block RAM or to an error response

`timescale 1ns/100ps
`default_nettype none

`include "io_macros.svh"

module io_addr_decode (
   input  wire               ram_clk,
   input  wire               rst_n_i,
   input  wire               deq_valid_i,
   input  io_pkg::io_req_t   deq_req_i,
   output logic              deq_pop_o,
   input  wire               resp_credit_i,
   output logic              ram_en_o,
   output io_pkg::io_strb_t  ram_we_o,
   output io_pkg::io_addr_t  ram_addr_o,
   output io_pkg::io_data_t  ram_wdata_o,
   input  io_pkg::io_data_t  ram_rdata_i,
   output logic              resp_valid_o,
   output io_pkg::io_resp_t  resp_o
);

   io_pkg::resp_cnt_t credit_cnt;   // granted, not yet answered
   logic              hit;
   logic              unmapped_q;

   ////////////////////////////////////////////////////////////
   // window decode

   assign hit = ((deq_req_i.addr & `BRAM_MASK) == `BRAM_BASE);

   // a response already in flight still owns one credit
   assign deq_pop_o = deq_valid_i &&
                      (credit_cnt > io_pkg::resp_cnt_t'(resp_valid_o));

   ////////////////////////////////////////////////////////////
   // RAM side

   assign ram_en_o    = deq_pop_o && hit;
   assign ram_we_o    = (ram_en_o && deq_req_i.write) ? deq_req_i.strb : '0;
   assign ram_addr_o  = deq_req_i.addr & ~`BRAM_MASK;   // offset in window
   assign ram_wdata_o = deq_req_i.wdata;

   ////////////////////////////////////////////////////////////
   // credits and response stage

   always_ff @(posedge ram_clk or negedge rst_n_i) begin
      if (!rst_n_i) begin
         credit_cnt   <= '0;
         resp_valid_o <= 1'b0;
         unmapped_q   <= 1'b0;
      end else begin
         credit_cnt   <= credit_cnt + io_pkg::resp_cnt_t'(resp_credit_i)
                                    - io_pkg::resp_cnt_t'(resp_valid_o);
         resp_valid_o <= deq_pop_o;     // lines up with RAM read latency
         unmapped_q   <= deq_pop_o && !hit;
      end
   end

   // misses answer with zero data
   assign resp_o.rdata = unmapped_q ? '0 : ram_rdata_i;
   assign resp_o.err   = unmapped_q;

   // every response issued must have been credited by the host
   assert property (@(posedge ram_clk) disable iff (!rst_n_i)
      resp_valid_o |-> (credit_cnt != '0))
      else $error("response credit counter underflow");

endmodule

`default_nettype wire

// File: rtl/io_req_queue.sv
// io request FIFO, hands a credit back to the host for every entry popped

`timescale 1ns/100ps
`default_nettype none

`include "io_macros.svh"

module io_req_queue (
   input  wire             ram_clk,
   input  wire             rst_n_i,
   input  wire             req_valid_i,
   input  io_pkg::io_req_t req_i,
   input  wire             deq_pop_i,
   output logic            deq_valid_o,
   output io_pkg::io_req_t deq_req_o,
   output logic            req_credit_o
);

   localparam int PTR_W = $clog2(`REQ_DEPTH);
   localparam int CNT_W = $clog2(`REQ_DEPTH + 1);

   io_pkg::io_req_t  mem [`REQ_DEPTH];
   logic [PTR_W-1:0] wr_ptr, rd_ptr;
   logic [CNT_W-1:0] count;

   ////////////////////////////////////////////////////////////
   // storage

   always_ff @(posedge ram_clk) begin
      if (req_valid_i) begin
         mem[wr_ptr] <= req_i;
      end
   end

   assign deq_req_o   = mem[rd_ptr];
   assign deq_valid_o = (count != '0);

   ////////////////////////////////////////////////////////////
   // pointers and occupancy

   always_ff @(posedge ram_clk or negedge rst_n_i) begin
      if (!rst_n_i) begin
         wr_ptr       <= '0;
         rd_ptr       <= '0;
         count        <= '0;
         req_credit_o <= 1'b0;
      end else begin
         if (req_valid_i) begin
            wr_ptr <= (wr_ptr == PTR_W'(`REQ_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
         end
         if (deq_pop_i) begin
            rd_ptr <= (rd_ptr == PTR_W'(`REQ_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
         end
         case ({req_valid_i, deq_pop_i})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
         req_credit_o <= deq_pop_i;   // slot freed, one credit back
      end
   end

   // host spent a credit it never had
   assert property (@(posedge ram_clk) disable iff (!rst_n_i)
      req_valid_i |-> (count != CNT_W'(`REQ_DEPTH)))
      else $error("request pushed into a full queue");

   // decoder popped an empty queue
   assert property (@(posedge ram_clk) disable iff (!rst_n_i)
      deq_pop_i |-> deq_valid_o)
      else $error("pop from an empty request queue");

endmodule

`default_nettype wire

// File: rtl/io_bram.sv
// io block RAM, 128-bit rows accessed one 32-bit lane at a time with byte strobes

`timescale 1ns/100ps
`default_nettype none

`include "io_macros.svh"

module io_bram (
   input  wire              ram_clk,
   input  wire              ram_en_i,
   input  io_pkg::io_strb_t ram_we_i,
   input  io_pkg::io_addr_t ram_addr_i,
   input  io_pkg::io_data_t ram_wdata_i,
   output io_pkg::io_data_t ram_rdata_o
);

   localparam int ROW_BYTES = `BRAM_ROW_W / 8;
   localparam int ROWS      = 2 ** (`BRAM_SIZE_LOG2 - $clog2(ROW_BYTES));
   localparam int LANE_LSB  = $clog2(`IO_DATA_W / 8);
   localparam int ROW_LSB   = $clog2(ROW_BYTES);

   io_pkg::bram_row_t      mem [ROWS];
   io_pkg::bram_row_addr_t row, row_q;
   io_pkg::bram_lane_t     lane, lane_q;
   logic [ROW_BYTES-1:0]   we_row;
   io_pkg::bram_row_t      wdata_row;
   io_pkg::bram_row_t      rd_shift;

   ////////////////////////////////////////////////////////////
   // lane packing

   assign row  = ram_addr_i[`BRAM_SIZE_LOG2-1:ROW_LSB];
   assign lane = ram_addr_i[ROW_LSB-1:LANE_LSB];

   assign we_row    = ROW_BYTES'(ram_we_i) << (lane * (`IO_DATA_W / 8));
   assign wdata_row = {(`BRAM_ROW_W / `IO_DATA_W){ram_wdata_i}};

   always_ff @(posedge ram_clk) begin
      if (ram_en_i) begin
         row_q  <= row;
         lane_q <= lane;
         for (int b = 0; b < ROW_BYTES; b++) begin
            if (we_row[b]) begin
               mem[row][b*8 +: 8] <= wdata_row[b*8 +: 8];
            end
         end
      end
   end

   // selected lane shifted down to bit 0
   assign rd_shift    = mem[row_q] >> (lane_q * `IO_DATA_W);
   assign ram_rdata_o = rd_shift[`IO_DATA_W-1:0];

   // enable stays known once it has settled out of reset
   assert property (@(posedge ram_clk)
      !$isunknown($past(ram_en_i)) |-> !$isunknown(ram_en_i))
      else $error("block RAM enable went unknown");

endmodule

`default_nettype wire

// File: rtl/io_pkg.sv
// io package with the bus word types and the request and response structs

`default_nettype none

`include "io_macros.svh"

package io_pkg;

   // plain vectors with a meaning
   typedef logic [`IO_ADDR_W-1:0]   io_addr_t;
   typedef logic [`IO_DATA_W-1:0]   io_data_t;
   typedef logic [`IO_DATA_W/8-1:0] io_strb_t;     // one per byte
   typedef logic [`RESP_CNT_W-1:0]  resp_cnt_t;

   // RAM geometry
   typedef logic [`BRAM_ROW_W-1:0] bram_row_t;
   typedef logic [`BRAM_SIZE_LOG2-$clog2(`BRAM_ROW_W/8)-1:0] bram_row_addr_t;
   typedef logic [$clog2(`BRAM_ROW_W/`IO_DATA_W)-1:0] bram_lane_t;

   ////////////////////////////////////////////////////////////
   // host request, one word, read or write

   typedef struct packed {
      logic     write;
      io_addr_t addr;
      io_data_t wdata;
      io_strb_t strb;
   } io_req_t;

   ////////////////////////////////////////////////////////////
   // response back to the host

   typedef struct packed {
      io_data_t rdata;
      logic     err;    // unmapped address
   } io_resp_t;

endpackage

`default_nettype wire

// File: rtl/io_macros.svh
// io block RAM path widths, RAM geometry, address window and queue depth

`ifndef IO_MACROS_SVH
`define IO_MACROS_SVH

////////////////////////////////////////////////////////////
// host bus

`define IO_ADDR_W       16          // byte address
`define IO_DATA_W       32          // one lite data word

////////////////////////////////////////////////////////////
// block RAM

`define BRAM_ROW_W      128         // always four words per row
`define BRAM_SIZE_LOG2  12          // 4 KB, 256 rows

// window decode, hit when (addr & mask) == base
`define BRAM_BASE       16'h8000
`define BRAM_MASK       16'hF000

////////////////////////////////////////////////////////////
// flow control

`define REQ_DEPTH       4           // also the host's starting credits
`define RESP_CNT_W      4

`endif
